//--- core_shell.f
rtl/core_shell_pkg.sv
rtl/sleep_ctrl.sv
rtl/reg_file.sv
rtl/lockstep_delay.sv
rtl/lockstep_check.sv
rtl/core_shell.sv
verif/core_shell_props.sv
verif/core_shell_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the core shell testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module core_shell_tb -f core_shell.f -o core_shell_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/core_shell_sim | tee /dev/stderr | grep -x "TEST RESULT: PASS" > /dev/null \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

//--- verif/core_shell_tb.sv
/*
  Testbench for the core shell. Drives the register file ports and the
  run/sleep inputs directly, and checks all outputs every cycle.
*/
`timescale 1ns/10ps
`default_nettype none

module core_shell_tb;

  localparam int ResetCycles = 10;
  localparam int NumRandOps  = 300;
  localparam int NumDirOps   = 80;
  localparam int NumOps      = NumRandOps + NumDirOps;
  localparam int ClkPeriodNs = 10;
  localparam int Seed        = 82;
  localparam int NumRegs     = core_shell_pkg::NumRegs;
  localparam int AddrW       = core_shell_pkg::RegAddrW;
  localparam int DataW       = core_shell_pkg::RegDataW;

  logic clk;
  logic rst_n;
  logic fetch_enable;
  logic core_busy;
  logic irq_pending;
  logic irq_nm;
  logic debug_req;
  logic core_sleep;
  logic alert_minor;
  core_shell_pkg::rf_wr_req_t  rf_wr;
  core_shell_pkg::rf_rd_req_t  rf_rd;
  core_shell_pkg::rf_rd_data_t rf_rd_data;

  // Reference model state
  logic [DataW-1:0] model_rf [NumRegs];
  logic             model_fetch_q;
  logic             model_busy_q;
  int unsigned      err_cnt;
  int unsigned      check_cnt;

  core_shell core_shell_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .fetch_enable_i (fetch_enable),
    .core_busy_i    (core_busy),
    .irq_pending_i  (irq_pending),
    .irq_nm_i       (irq_nm),
    .debug_req_i    (debug_req),
    .rf_wr_i        (rf_wr),
    .rf_rd_i        (rf_rd),
    .rf_rd_data_o   (rf_rd_data),
    .core_sleep_o   (core_sleep),
    .alert_minor_o  (alert_minor)
  );

  always #(ClkPeriodNs / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Busy counts one cycle late, wake sources at once
  function automatic logic awake_ref();
    return model_fetch_q && (model_busy_q || irq_pending || irq_nm || debug_req);
  endfunction

  function automatic logic [DataW-1:0] read_ref(input logic [AddrW-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    return model_rf[addr];
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_fetch_q <= 1'b0;
      model_busy_q  <= 1'b0;
      for (int i = 0; i < NumRegs; i++) begin
        model_rf[i] <= '0;
      end
    end else begin
      if (rf_wr.we && awake_ref() && rf_wr.addr != '0) begin
        model_rf[rf_wr.addr] <= rf_wr.data;
      end
      model_fetch_q <= model_fetch_q || fetch_enable;
      model_busy_q  <= core_busy;
    end
  end

  task automatic compare_outputs();
    logic             exp_sleep;
    logic [DataW-1:0] exp_a;
    logic [DataW-1:0] exp_b;
    exp_sleep = !awake_ref();
    exp_a     = read_ref(rf_rd.addr_a);
    exp_b     = read_ref(rf_rd.addr_b);
    check_cnt++;
    if (core_sleep !== exp_sleep) begin
      err_cnt++;
      $display("[ERROR] %0t core_sleep_o: expected %0b, actual %0b",
               $time, exp_sleep, core_sleep);
    end
    if (rf_rd_data.data_a !== exp_a) begin
      err_cnt++;
      $display("[ERROR] %0t rf_rd_data_o.data_a: expected %h, actual %h",
               $time, exp_a, rf_rd_data.data_a);
    end
    if (rf_rd_data.data_b !== exp_b) begin
      err_cnt++;
      $display("[ERROR] %0t rf_rd_data_o.data_b: expected %h, actual %h",
               $time, exp_b, rf_rd_data.data_b);
    end
    if (alert_minor !== 1'b0) begin
      err_cnt++;
      $display("[ERROR] %0t alert_minor_o: expected 0, actual %0b", $time, alert_minor);
    end
  endtask

  // Inputs settle long before the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      compare_outputs();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic we, input logic [AddrW-1:0] waddr,
                             input logic [DataW-1:0] wdata,
                             input logic [AddrW-1:0] raddr_a,
                             input logic [AddrW-1:0] raddr_b);
    @(posedge clk);
    #1;
    rf_wr.we     = we;
    rf_wr.addr   = waddr;
    rf_wr.data   = wdata;
    rf_rd.addr_a = raddr_a;
    rf_rd.addr_b = raddr_b;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      rf_wr.we = 1'b0;
    end
  endtask

  initial begin
    logic [AddrW-1:0] waddr;
    logic [AddrW-1:0] raddr;
    logic [AddrW-1:0] last_addr;
    void'($urandom(Seed));
    clk          = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    core_busy    = 1'b0;
    irq_pending  = 1'b0;
    irq_nm       = 1'b0;
    debug_req    = 1'b0;
    rf_wr        = '0;
    rf_rd        = '0;
    err_cnt      = 0;
    check_cnt    = 0;
    last_addr    = '0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // No fetch enable yet, so busy and irq must not wake the core
    core_busy   = 1'b1;
    irq_pending = 1'b1;
    for (int i = 0; i < NumRegs; i++) begin
      drive_cycle(1'b1, AddrW'(i), $urandom(), AddrW'(i), AddrW'(NumRegs - 1 - i));
    end

    drive_cycle(1'b0, '0, '0, AddrW'(1), AddrW'(2));
    irq_pending  = 1'b0;
    fetch_enable = 1'b1;
    idle_cycles(1);
    fetch_enable = 1'b0;
    idle_cycles(3);
    // Each wake source in turn holds the core awake
    core_busy   = 1'b0;
    irq_pending = 1'b1;
    idle_cycles(3);
    irq_pending = 1'b0;
    irq_nm      = 1'b1;
    idle_cycles(3);
    irq_nm    = 1'b0;
    debug_req = 1'b1;
    idle_cycles(3);
    debug_req = 1'b0;
    idle_cycles(3);

    // Random traffic while awake
    core_busy = 1'b1;
    idle_cycles(1);
    for (int n = 0; n < NumRandOps; n++) begin
      waddr = AddrW'($urandom());
      raddr = ($urandom() % 2 == 0) ? last_addr : AddrW'($urandom());
      drive_cycle(($urandom() % 4) != 0, waddr, $urandom(), raddr, waddr);
      last_addr = waddr;
    end

    // Writes while asleep are lost
    core_busy = 1'b0;
    idle_cycles(2);
    for (int i = 1; i <= 8; i++) begin
      drive_cycle(1'b1, AddrW'(i), $urandom(), AddrW'(i), '0);
    end
    core_busy = 1'b1;
    idle_cycles(1);
    for (int i = 1; i <= 8; i++) begin
      drive_cycle(1'b0, '0, '0, AddrW'(i), AddrW'(i + 8));
    end
    idle_cycles(core_shell_pkg::LockstepDelay + 2);

    $display("Run complete: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #((ResetCycles + NumOps + 100) * ClkPeriodNs);
    $display("Watchdog expired before the stimulus finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/core_shell_props.sv
/*
  Bound checks on the run/sleep clock enable and the lockstep alert.
*/
`timescale 1ns/10ps
`default_nettype none

module core_shell_props (
  input logic clk_i,
  input logic rst_ni,
  input logic fetch_enable_i,
  input logic irq_pending_i,
  input logic irq_nm_i,
  input logic debug_req_i,
  input logic clk_en_i,
  input logic core_sleep_i,
  input logic alert_minor_i
);

  logic fetch_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  alert_never_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !alert_minor_i)
    else $error("lockstep alert raised");

  asleep_until_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_seen_q |-> core_sleep_i)
    else $error("core awake before fetch enable was seen");

  // Any wake source keeps the core running once fetch is enabled
  wake_keeps_awake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_seen_q && (irq_pending_i || irq_nm_i || debug_req_i) |-> clk_en_i)
    else $error("clock enable low while a wake source is raised");

endmodule

bind core_shell core_shell_props u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .fetch_enable_i (fetch_enable_i),
  .irq_pending_i  (irq_pending_i),
  .irq_nm_i       (irq_nm_i),
  .debug_req_i    (debug_req_i),
  .clk_en_i       (clk_en),
  .core_sleep_i   (core_sleep_o),
  .alert_minor_i  (alert_minor_o)
);

`default_nettype wire

//--- rtl/core_shell.sv
/*
  Core shell top with run/sleep control, register file and lockstep check.
  Register writes are dropped while the clock enable is low.
*/
`timescale 1ns/10ps
`default_nettype none

module core_shell (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fetch_enable_i,
  input  logic                        core_busy_i,
  input  logic                        irq_pending_i,
  input  logic                        irq_nm_i,
  input  logic                        debug_req_i,
  input  core_shell_pkg::rf_wr_req_t  rf_wr_i,
  input  core_shell_pkg::rf_rd_req_t  rf_rd_i,
  output core_shell_pkg::rf_rd_data_t rf_rd_data_o,
  output logic                        core_sleep_o,
  output logic                        alert_minor_o
);

  logic                       clk_en;
  core_shell_pkg::rf_wr_req_t rf_wr_gated;

  sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .irq_pending_i  (irq_pending_i),
    .irq_nm_i       (irq_nm_i),
    .debug_req_i    (debug_req_i),
    .clk_en_o       (clk_en),
    .core_sleep_o   (core_sleep_o)
  );

  // Stands in for the clock gate
  assign rf_wr_gated = core_shell_pkg::rf_wr_req_t'{
    we:   rf_wr_i.we & clk_en,
    addr: rf_wr_i.addr,
    data: rf_wr_i.data
  };

  ////////////////////////////////////////////////////////////////////////////
  // Main register file and its lockstep shadow
  ////////////////////////////////////////////////////////////////////////////

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (rf_wr_gated),
    .rd_i      (rf_rd_i),
    .rd_data_o (rf_rd_data_o)
  );

  lockstep_check u_lockstep_check (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wr_i          (rf_wr_gated),
    .rd_i          (rf_rd_i),
    .rd_data_i     (rf_rd_data_o),
    .alert_minor_o (alert_minor_o)
  );

endmodule

`default_nettype wire

//--- rtl/lockstep_check.sv
/*
  Lockstep check with a shadow register file fed LockstepDelay cycles late.
  Main read data is delayed by the same amount and compared.
  alert_minor_o pulses one cycle after each mismatch.
*/
`timescale 1ns/10ps
`default_nettype none

module lockstep_check (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  core_shell_pkg::rf_wr_req_t  wr_i,
  input  core_shell_pkg::rf_rd_req_t  rd_i,
  input  core_shell_pkg::rf_rd_data_t rd_data_i,
  output logic                        alert_minor_o
);

  core_shell_pkg::rf_wr_req_t  wr_dly;
  core_shell_pkg::rf_rd_req_t  rd_dly;
  core_shell_pkg::rf_rd_data_t rd_data_dly;
  core_shell_pkg::rf_rd_data_t shadow_rd_data;
  logic                        mismatch;
  logic                        alert_q;

  ////////////////////////////////////////////////////////////////////////////
  // Delayed copies of the main traffic
  ////////////////////////////////////////////////////////////////////////////

  lockstep_delay #(.payload_t(core_shell_pkg::rf_wr_req_t)) u_wr_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (wr_i),
    .data_o (wr_dly)
  );

  lockstep_delay #(.payload_t(core_shell_pkg::rf_rd_req_t)) u_rd_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (rd_i),
    .data_o (rd_dly)
  );

  lockstep_delay #(.payload_t(core_shell_pkg::rf_rd_data_t)) u_rd_data_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (rd_data_i),
    .data_o (rd_data_dly)
  );

  // Shadow copy
  reg_file u_shadow_rf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (wr_dly),
    .rd_i      (rd_dly),
    .rd_data_o (shadow_rd_data)
  );

  assign mismatch = (shadow_rd_data != rd_data_dly);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= mismatch;
    end
  end

  assign alert_minor_o = alert_q;

endmodule

`default_nettype wire

//--- rtl/lockstep_delay.sv
/*
  Fixed delay line of LockstepDelay stages for any packed payload.
  Stages reset to zero, so a delayed request starts out inactive.
*/
`timescale 1ns/10ps
`default_nettype none

module lockstep_delay #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  output payload_t data_o
);

  localparam int unsigned Depth = core_shell_pkg::LockstepDelay;

  payload_t [Depth-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest stage
  assign data_o = stage_q[Depth-1];

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
/*
  Flip-flop register file, two combinational read ports, one write port.
  Address 0 always reads zero and ignores writes.
*/
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  core_shell_pkg::rf_wr_req_t  wr_i,
  input  core_shell_pkg::rf_rd_req_t  rd_i,
  output core_shell_pkg::rf_rd_data_t rd_data_o
);

  logic [core_shell_pkg::NumRegs-1:0][core_shell_pkg::RegDataW-1:0] rf_q;

  // x0 is a constant
  assign rf_q[0] = '0;

  for (genvar i = 1; i < core_shell_pkg::NumRegs; i++) begin : gen_regs
    logic                              we;
    logic [core_shell_pkg::RegDataW-1:0] reg_q;

    assign we = wr_i.we && (wr_i.addr == core_shell_pkg::RegAddrW'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        reg_q <= '0;
      end else if (we) begin
        reg_q <= wr_i.data;
      end
    end

    assign rf_q[i] = reg_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  assign rd_data_o = core_shell_pkg::rf_rd_data_t'{
    data_a: rf_q[rd_i.addr_a],
    data_b: rf_q[rd_i.addr_b]
  };

endmodule

`default_nettype wire

//--- rtl/sleep_ctrl.sv
/*
  Run or sleep control for the core shell.
  Fetch enable is captured once and only cleared by reset.
  The busy flag acts one cycle late, the wake sources act at once.
*/
`timescale 1ns/10ps
`default_nettype none

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic core_busy_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic debug_req_i,
  output logic clk_en_o,
  output logic core_sleep_o
);

  // RUN and SLEEP also hold the registered busy flag
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    RUN   = 2'd1,
    SLEEP = 2'd2
  } state_e;

  state_e state_q, state_d;
  logic   fetch_seen;
  logic   wake;

  assign fetch_seen = (state_q != OFF) || fetch_enable_i;
  assign wake       = irq_pending_i | irq_nm_i | debug_req_i;

  always_comb begin
    state_d = OFF;
    if (fetch_seen) begin
      state_d = core_busy_i ? RUN : SLEEP;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= OFF;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    case (state_q)
      RUN:     clk_en_o = 1'b1;
      SLEEP:   clk_en_o = wake;
      default: clk_en_o = 1'b0;
    endcase
  end

  assign core_sleep_o = ~clk_en_o;

endmodule

`default_nettype wire

//--- rtl/core_shell_pkg.sv
/*
  Shared sizes and request types for the core shell.
  The register file is fixed at 32 x 32 bits with x0 reading zero.
*/
`default_nettype none

package core_shell_pkg;

  // Register file geometry
  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegAddrW = 5;
  localparam int unsigned RegDataW = 32;

  // Cycles the shadow copy trails the main copy
  localparam int unsigned LockstepDelay = 2;

  typedef struct packed {
    logic                we;
    logic [RegAddrW-1:0] addr;
    logic [RegDataW-1:0] data;
  } rf_wr_req_t;

  typedef struct packed {
    logic [RegAddrW-1:0] addr_a;
    logic [RegAddrW-1:0] addr_b;
  } rf_rd_req_t;

  typedef struct packed {
    logic [RegDataW-1:0] data_a;
    logic [RegDataW-1:0] data_b;
  } rf_rd_data_t;

endpackage

`default_nettype wire
